// ==== divmmc.f ====
verilog/divmmc_bus_pkg.sv
verilog/divmmc_mem_pkg.sv
verilog/divmmc_port_decode.sv
verilog/divmmc_automap.sv
verilog/divmmc_spi.sv
verilog/divmmc_mem_map.sv
verilog/divmmc_top.sv
sim/divmmc_tb.sv

// ==== Makefile ====
SRCS := $(wildcard verilog/*.sv) $(wildcard sim/*.sv)

.PHONY: all run clean

all: obj_dir/Vdivmmc_tb

obj_dir/Vdivmmc_tb: divmmc.f $(SRCS)
	verilator --binary --timing --assert -f divmmc.f --top-module divmmc_tb -o Vdivmmc_tb

run: obj_dir/Vdivmmc_tb
	./obj_dir/Vdivmmc_tb

clean:
	rm -rf obj_dir

// ==== sim/divmmc_tb.sv ====
// self-checking testbench for divmmc_top, driving CPU bus cycles and modelling the SD card
`timescale 1ns/1ps

module divmmc_tb
	import divmmc_mem_pkg::*;
;

	logic        clk;
	logic        reset_n;
	logic        enable;
	logic [15:0] a;
	logic        wr_n;
	logic        rd_n;
	logic        mreq_n;
	logic        m1_n;
	logic [7:0]  din;
	logic [7:0]  dout;
	logic        paged_in;
	ctrl_reg_t   ctrl;
	mem_sel_t    mem_sel;
	logic        sd_cs;
	logic        sd_sck;
	logic        sd_mosi;
	logic        sd_miso;

	// reference state of the mapping logic
	logic [7:0]  ref_ctrl;
	logic        ref_cs;
	logic        ref_trig;
	logic        ref_paged;

	// SD card model
	logic [7:0]  card_resp;
	logic [7:0]  card_in = 8'h00;
	logic [2:0]  card_falls = 3'd0;
	int          card_bits = 0;

	divmmc_top #(
		.SPI_DIV_LOG2 (0)
	) u_divmmc_top (
		.clk      (clk),
		.reset_n  (reset_n),
		.enable   (enable),
		.a        (a),
		.wr_n     (wr_n),
		.rd_n     (rd_n),
		.mreq_n   (mreq_n),
		.m1_n     (m1_n),
		.din      (din),
		.dout     (dout),
		.paged_in (paged_in),
		.ctrl     (ctrl),
		.mem_sel  (mem_sel),
		.sd_cs    (sd_cs),
		.sd_sck   (sd_sck),
		.sd_mosi  (sd_mosi),
		.sd_miso  (sd_miso)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// card takes MOSI on SCK rising and moves to the next MISO bit on SCK falling
	assign sd_miso = card_resp[3'd7 - card_falls];

	always @(posedge sd_sck) begin
		if (reset_n) begin
			card_in   <= {card_in[6:0], sd_mosi};
			card_bits <= card_bits + 1;
		end
	end

	always @(negedge sd_sck) begin
		if (reset_n)
			card_falls <= card_falls + 3'd1;
	end

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (exp === act) else begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			$display("** FAIL **");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// fetch class from the entry and exit address rules, entry first
	function automatic int fetch_kind(input logic [15:0] addr);
		if (addr == 16'h0000 || addr == 16'h0008 || addr == 16'h0038 ||
			addr == 16'h0066 || addr == 16'h04C6 || addr == 16'h0562)
			return 1;
		if (addr[15:8] == 8'h3D)
			return 2;
		if (addr >= 16'h1FF8 && addr <= 16'h1FFF)
			return 3;
		return 0;
	endfunction

	function automatic mem_sel_t expected_sel(input logic [15:0] addr, input logic pg,
		input ctrl_reg_t c);
		mem_sel_t s;
		s = '0;
		if (c.conmem || pg) begin
			if (addr < 16'h2000) begin
				if (c.conmem) begin
					s.rom_cs = 1'b1;
				end else if (c.mapram) begin
					s.ram_cs = 1'b1;
					s.ram_page = 4'd3;
					s.write_protect = 1'b1;
				end else begin
					s.rom_cs = 1'b1;
					s.write_protect = 1'b1;
				end
			end else if (addr < 16'h4000) begin
				s.ram_cs = 1'b1;
				s.ram_page = c.sram_page;
				s.write_protect = c.mapram && !c.conmem && (c.sram_page == 4'd3);
			end
		end
		return s;
	endfunction

	// one bus cycle: drive on the falling edge, check after the rising edge
	task automatic drive_cycle(input logic en, input logic [15:0] addr, input logic w_n,
		input logic r_n, input logic mq_n, input logic m_n, input logic [7:0] data);
		int  kind;
		logic next_paged;
		@(negedge clk);
		enable = en;
		a      = addr;
		wr_n   = w_n;
		rd_n   = r_n;
		mreq_n = mq_n;
		m1_n   = m_n;
		din    = data;
		#2;
		check_value("mem_sel", 32'(expected_sel(addr, ref_paged, ctrl_reg_t'(ref_ctrl))),
			32'(mem_sel));
		kind = (!mq_n && !r_n && !m_n) ? fetch_kind(addr) : 0;
		if (en && !w_n && addr[3:0] == 4'h3)
			ref_ctrl = data;
		if (en && !w_n && addr[3:0] == 4'h7)
			ref_cs = data[0];
		next_paged = (kind == 2) ? 1'b1 : (m_n ? ref_trig : ref_paged);
		if (kind == 1 || kind == 2)
			ref_trig = 1'b1;
		else if (kind == 3)
			ref_trig = 1'b0;
		ref_paged = next_paged;
		@(posedge clk);
		#1;
		check_value("paged_in", 32'(ref_paged), 32'(paged_in));
		check_value("ctrl", 32'(ref_ctrl), 32'(ctrl));
		check_value("sd_cs", 32'(ref_cs), 32'(sd_cs));
	endtask

	task automatic port_write(input logic [15:0] addr, input logic [7:0] data);
		drive_cycle(1'b1, addr, 1'b0, 1'b1, 1'b1, 1'b1, data);
	endtask

	task automatic m1_fetch(input logic [15:0] addr);
		drive_cycle(1'b0, addr, 1'b1, 1'b0, 1'b0, 1'b0, 8'h00);
	endtask

	task automatic mem_read(input logic [15:0] addr);
		drive_cycle(1'b0, addr, 1'b1, 1'b0, 1'b0, 1'b1, 8'h00);
	endtask

	task automatic idle_cycle(input logic [15:0] addr);
		drive_cycle(1'b0, addr, 1'b1, 1'b1, 1'b1, 1'b1, 8'h00);
	endtask

	// port B write sends tx, port B read sends 0xFF
	task automatic spi_transfer(input logic is_write, input logic [7:0] tx,
		input logic [7:0] resp);
		int start;
		int n;
		card_resp = resp;
		start = card_bits;
		drive_cycle(1'b1, 16'h00EB, !is_write, is_write, 1'b1, 1'b1, tx);
		idle_cycle(16'h8000);
		n = 0;
		while (!(card_bits == start + 8 && sd_sck == 1'b0)) begin
			@(negedge clk);
			n++;
			if (n > 200) begin
				$display("timeout: SPI transfer did not complete");
				$display("** FAIL **");
				$fatal(1, "SPI timeout");
			end
		end
		check_value("spi mosi byte", 32'(is_write ? tx : 8'hFF), 32'(card_in));
		check_value("spi dout", 32'(resp), 32'(dout));
	endtask

	initial begin
		#2_000_000;
		$display("timeout: simulation did not finish");
		$display("** FAIL **");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [15:0] addr;
		int kind;
		void'($urandom(42303));
		reset_n = 1'b0;
		enable = 1'b0;
		a = 16'h0000;
		wr_n = 1'b1;
		rd_n = 1'b1;
		mreq_n = 1'b1;
		m1_n = 1'b1;
		din = 8'h00;
		card_resp = 8'hFF;
		ref_ctrl = 8'h00;
		ref_cs = 1'b1;
		ref_trig = 1'b0;
		ref_paged = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		#1;
		check_value("reset paged_in", 0, 32'(paged_in));
		check_value("reset ctrl", 0, 32'(ctrl));
		check_value("reset sd_sck", 0, 32'(sd_sck));
		check_value("reset sd_mosi", 0, 32'(sd_mosi));
		check_value("reset sd_cs", 1, 32'(sd_cs));

		// port writes
		port_write(16'h00E3, 8'h85);
		check_value("port 3 write", 32'h85, 32'(ctrl));
		port_write(16'h00E5, 8'hFF);
		check_value("other port write", 32'h85, 32'(ctrl));
		port_write(16'h00E7, 8'h00);
		check_value("port 7 write", 0, 32'(sd_cs));
		port_write(16'h00E3, 8'h00);

		// SPI
		spi_transfer(1'b1, 8'hA5, 8'h3C);
		spi_transfer(1'b0, 8'h00, 8'hC9);
		for (int i = 0; i < 4; i++)
			spi_transfer(1'($urandom % 2), 8'($urandom), 8'($urandom));

		// automapper
		m1_fetch(16'h0066);
		check_value("delayed entry during fetch", 0, 32'(paged_in));
		idle_cycle(16'h0067);
		check_value("delayed entry after m1", 1, 32'(paged_in));
		m1_fetch(16'h1FFC);
		check_value("exit during fetch", 1, 32'(paged_in));
		idle_cycle(16'h1FFD);
		check_value("exit after m1", 0, 32'(paged_in));
		m1_fetch(16'h3D2A);
		check_value("immediate entry", 1, 32'(paged_in));
		m1_fetch(16'h1FF8);
		idle_cycle(16'h0000);
		mem_read(16'h0000);
		idle_cycle(16'h0001);
		check_value("non-M1 read", 0, 32'(paged_in));

		// memory map over random control and paging states
		for (int i = 0; i < 40; i++) begin
			port_write(16'h00E3, 8'($urandom));
			if ($urandom % 2)
				m1_fetch(16'h3D00);
			else
				m1_fetch(16'h1FF8);
			for (int j = 0; j < 4; j++)
				idle_cycle(16'($urandom));
		end

		// random mix, port B left out
		for (int i = 0; i < 300; i++) begin
			kind = $urandom % 4;
			addr = 16'($urandom);
			case (kind)
				0: begin
					if (addr[3:0] == 4'hB)
						addr[3:0] = 4'h3;
					port_write(addr, 8'($urandom));
				end
				1: begin
					case ($urandom % 5)
						0: addr = 16'h0038;
						1: addr = 16'h04C6;
						2: addr = {8'h3D, addr[7:0]};
						3: addr = {13'h03FF, addr[2:0]};
						default: ;
					endcase
					m1_fetch(addr);
				end
				2: mem_read(addr);
				default: idle_cycle(addr);
			endcase
		end

		$display("** PASS **");
		$finish;
	end

endmodule

// ==== verilog/divmmc_top.sv ====
// DivMMC top level joining port decode, automapper, SPI master and memory map
`timescale 1ns/1ps

module divmmc_top
	import divmmc_bus_pkg::*, divmmc_mem_pkg::*;
#(
	parameter int unsigned SPI_DIV_LOG2 = 0
) (
	input  logic        clk,
	input  logic        reset_n,

	// CPU bus
	input  logic        enable,
	input  logic [15:0] a,
	input  logic        wr_n,
	input  logic        rd_n,
	input  logic        mreq_n,
	input  logic        m1_n,
	input  logic [7:0]  din,
	output logic [7:0]  dout,

	// mapping state
	output logic        paged_in,
	output ctrl_reg_t   ctrl,
	output mem_sel_t    mem_sel,

	// SD card
	output logic        sd_cs,
	output logic        sd_sck,
	output logic        sd_mosi,
	input  logic        sd_miso
);

	bus_cmd_t cmd;

	divmmc_port_decode u_port_decode (
		.enable (enable),
		.a      (a),
		.wr_n   (wr_n),
		.rd_n   (rd_n),
		.mreq_n (mreq_n),
		.m1_n   (m1_n),
		.cmd    (cmd)
	);

	divmmc_automap u_automap (
		.clk      (clk),
		.reset_n  (reset_n),
		.cmd      (cmd),
		.din      (din),
		.m1_n     (m1_n),
		.ctrl     (ctrl),
		.sd_cs    (sd_cs),
		.paged_in (paged_in)
	);

	divmmc_spi #(
		.SPI_DIV_LOG2 (SPI_DIV_LOG2)
	) u_spi (
		.clk       (clk),
		.reset_n   (reset_n),
		.tx_strobe (cmd.spi_tx),
		.rx_strobe (cmd.spi_rx),
		.din       (din),
		.sd_miso   (sd_miso),
		.dout      (dout),
		.sd_sck    (sd_sck),
		.sd_mosi   (sd_mosi)
	);

	divmmc_mem_map u_mem_map (
		.a_hi     (a[15:13]),
		.paged_in (paged_in),
		.ctrl     (ctrl),
		.sel      (mem_sel)
	);

endmodule

// ==== verilog/divmmc_mem_map.sv ====
// combinational DivMMC memory map from CPU address, paging state and control register
`timescale 1ns/1ps

module divmmc_mem_map
	import divmmc_mem_pkg::*;
(
	input  logic [2:0] a_hi,
	input  logic       paged_in,
	input  ctrl_reg_t  ctrl,
	output mem_sel_t   sel
);

	logic active;

	assign active = ctrl.conmem || paged_in;

	always_comb begin
		sel.rom_cs        = 1'b0;
		sel.ram_cs        = 1'b0;
		sel.ram_page      = '0;
		sel.write_protect = 1'b0;

		if (active) begin
			case (a_hi)
				// 0000-1FFF
				3'd0: begin
					if (ctrl.conmem) begin
						sel.rom_cs = 1'b1;
					end else if (ctrl.mapram) begin
						sel.ram_cs        = 1'b1;
						sel.ram_page      = mapram_page;
						sel.write_protect = 1'b1;
					end else begin
						sel.rom_cs        = 1'b1;
						sel.write_protect = 1'b1;
					end
				end
				// 2000-3FFF, banked RAM
				3'd1: begin
					sel.ram_cs        = 1'b1;
					sel.ram_page      = ctrl.sram_page;
					sel.write_protect = ctrl.mapram && !ctrl.conmem &&
						(ctrl.sram_page == mapram_page);
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== verilog/divmmc_spi.sv ====
// SPI mode-0 byte master for the SD card, started by port B write or read strobes
`timescale 1ns/1ps

module divmmc_spi #(
	parameter int unsigned SPI_DIV_LOG2 = 0
) (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       tx_strobe,
	input  logic       rx_strobe,
	input  logic [7:0] din,
	input  logic       sd_miso,
	output logic [7:0] dout,
	output logic       sd_sck,
	output logic       sd_mosi
);

	localparam int unsigned DIV_W = (SPI_DIV_LOG2 > 0) ? SPI_DIV_LOG2 : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'((1 << SPI_DIV_LOG2) - 1);

	logic             busy;
	logic [DIV_W-1:0] div_cnt;
	// half period index, odd means SCK high
	logic [3:0]       phase;
	logic [7:0]       shift;
	logic             miso_bit;
	logic             half_end;

	assign half_end = busy && (div_cnt == DIV_LAST);
	assign sd_sck   = phase[0];
	assign sd_mosi  = busy && shift[7];

	// divider and half period counter
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy    <= 1'b0;
			div_cnt <= '0;
			phase   <= '0;
		end else if (!busy) begin
			div_cnt <= '0;
			phase   <= '0;
			if (tx_strobe || rx_strobe)
				busy <= 1'b1;
		end else if (half_end) begin
			div_cnt <= '0;
			phase   <= phase + 4'd1;
			if (phase == 4'd15)
				busy <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// sample MISO on SCK rising, shift on SCK falling
	always_ff @(posedge clk) begin
		if (!busy) begin
			if (tx_strobe)
				shift <= din;
			else if (rx_strobe)
				shift <= 8'hFF;
		end else if (half_end) begin
			if (!phase[0])
				miso_bit <= sd_miso;
			else
				shift <= {shift[6:0], miso_bit};
			if (phase == 4'd15)
				dout <= {shift[6:0], miso_bit};
		end
	end

	// a strobe arriving mid-transfer is dropped
	assert property (@(posedge clk) disable iff (!reset_n) busy |-> !(tx_strobe || rx_strobe))
		else $warning("spi: strobe ignored during a transfer");

endmodule

// ==== verilog/divmmc_automap.sv ====
// DivMMC control register, SD card select and M1-fetch automapper state
`timescale 1ns/1ps

module divmmc_automap
	import divmmc_bus_pkg::*, divmmc_mem_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  bus_cmd_t   cmd,
	input  logic [7:0] din,
	input  logic       m1_n,
	output ctrl_reg_t  ctrl,
	output logic       sd_cs,
	output logic       paged_in
);

	// armed by an entry fetch, cleared by an exit fetch
	logic m1_trigger;

	// port 3 and port 7 writes
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			ctrl  <= '0;
			sd_cs <= 1'b1;
		end else begin
			if (cmd.ctrl_wr)
				ctrl <= ctrl_reg_t'(din);
			if (cmd.cs_wr)
				sd_cs <= din[0];
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			m1_trigger <= 1'b0;
			paged_in   <= 1'b0;
		end else begin
			case (cmd.fetch)
				fetch_entry_delayed:   m1_trigger <= 1'b1;
				fetch_entry_immediate: m1_trigger <= 1'b1;
				fetch_exit_delayed:    m1_trigger <= 1'b0;
				default: ;
			endcase

			// delayed changes land once the fetch cycle is over
			if (cmd.fetch == fetch_entry_immediate)
				paged_in <= 1'b1;
			else if (m1_n)
				paged_in <= m1_trigger;
		end
	end

	// paged_in rises only on a 3Dxx fetch or at an m1_n-high edge
	property p_paged_in_rise;
		@(posedge clk) disable iff (!reset_n)
		$rose(paged_in) |->
			$past(cmd.fetch == fetch_entry_immediate) || $past(m1_n);
	endproperty

	assert property (p_paged_in_rise)
		else $error("automap: paged_in rose without an entry fetch");

endmodule

// ==== verilog/divmmc_port_decode.sv ====
// combinational decode of each CPU bus cycle into port strobes and an M1 fetch class
`timescale 1ns/1ps

module divmmc_port_decode
	import divmmc_bus_pkg::*;
(
	input  logic        enable,
	input  logic [15:0] a,
	input  logic        wr_n,
	input  logic        rd_n,
	input  logic        mreq_n,
	input  logic        m1_n,
	output bus_cmd_t    cmd
);

	logic       m1_read;
	logic       entry_delayed;
	logic       entry_immediate;
	logic       exit_delayed;
	logic [3:0] port_strobes;

	// opcode fetch from memory
	assign m1_read = !mreq_n && !rd_n && !m1_n;

	// rst vectors, nmi and the tape loader hooks
	assign entry_delayed = m1_read &&
		(a inside {16'h0000, 16'h0008, 16'h0038, 16'h0066, 16'h04C6, 16'h0562});

	// 3Dxx pages in on the fetch itself
	assign entry_immediate = m1_read && (a[15:8] == 8'h3D);

	// 1FF8 to 1FFF
	assign exit_delayed = m1_read && (a[15:3] == 13'h03FF);

	always_comb begin
		cmd.ctrl_wr = enable && !wr_n && (a[3:0] == port_ctrl);
		cmd.cs_wr   = enable && !wr_n && (a[3:0] == port_cs);
		cmd.spi_tx  = enable && !wr_n && (a[3:0] == port_spi);
		cmd.spi_rx  = enable && !rd_n && (a[3:0] == port_spi);

		// entry wins over exit
		if (entry_delayed)
			cmd.fetch = fetch_entry_delayed;
		else if (entry_immediate)
			cmd.fetch = fetch_entry_immediate;
		else if (exit_delayed)
			cmd.fetch = fetch_exit_delayed;
		else
			cmd.fetch = fetch_none;
	end

	assign port_strobes = {cmd.ctrl_wr, cmd.cs_wr, cmd.spi_tx, cmd.spi_rx};

	// at most one port strobe per cycle
	always_comb begin
		if (!$isunknown(port_strobes))
			assert ($onehot0(port_strobes))
				else $error("port decode: more than one port strobe active");
	end

endmodule

// ==== verilog/divmmc_mem_pkg.sv ====
// control register and memory select types shared by the DivMMC automapper, memory map and top
package divmmc_mem_pkg;

	// RAM page that MAPRAM puts in place of the ROM
	localparam logic [3:0] mapram_page = 4'd3;

	// control byte written through port 3
	typedef struct packed {
		logic       conmem;
		logic       mapram;
		logic [1:0] reserved;
		logic [3:0] sram_page;
	} ctrl_reg_t;

	// ROM/RAM select for the current CPU address
	typedef struct packed {
		logic       rom_cs;
		logic       ram_cs;
		logic [3:0] ram_page;
		logic       write_protect;
	} mem_sel_t;

endpackage

// ==== verilog/divmmc_bus_pkg.sv ====
// CPU bus types and I/O port numbers for the DivMMC decoder, automapper and top level
package divmmc_bus_pkg;

	// low address nibble of each I/O port
	localparam logic [3:0] port_ctrl = 4'h3;
	localparam logic [3:0] port_cs   = 4'h7;
	localparam logic [3:0] port_spi  = 4'hB;

	// what an M1 opcode fetch means to the automapper
	typedef enum logic [1:0] {
		fetch_none,
		fetch_entry_delayed,
		fetch_entry_immediate,
		fetch_exit_delayed
	} fetch_class_t;

	// one decoded bus cycle
	typedef struct packed {
		logic         ctrl_wr;
		logic         cs_wr;
		logic         spi_tx;
		logic         spi_rx;
		fetch_class_t fetch;
	} bus_cmd_t;

endpackage
